// File: sources.f
+incdir+tests
logic/mips_pkg.sv
logic/reg_file.sv
logic/alu.sv
logic/muldiv_unit.sv
logic/wb_exec_ctrl.sv
logic/exec_top.sv
tests/tb_exec_top.sv

// File: run_sim.sh
#!/bin/sh
# Build with Verilator and run; the exit status carries pass or fail
cd "$(dirname "$0")" && \
	verilator --binary --timing --assert --top-module tb_exec_top \
		-f sources.f -o sim_exec && \
	./obj_dir/sim_exec || exit 1

// File: tests/mips_model.svh
`ifndef MIPS_MODEL_SVH
`define MIPS_MODEL_SVH

// Architectural state as the host should observe it
word_t      model_gpr [32];
word_t      model_hi;
word_t      model_lo;
logic [1:0] model_status; // {illegal, branch taken}

function automatic void model_reset();
	for (int i = 0; i < 32; i++) begin
		model_gpr[5'(i)] = '0;
	end
	model_hi     = '0;
	model_lo     = '0;
	model_status = 2'b00;
endfunction

function automatic void model_write_gpr(input reg_idx_t idx, input word_t val);
	if (idx != 5'd0) begin
		model_gpr[idx] = val; // r0 stays zero
	end
endfunction

// Applies one instruction to the model state
function automatic void model_exec(input instr_t ins);
	logic [5:0]         op;
	logic [5:0]         fn;
	word_t              a;
	word_t              b;
	logic signed [31:0] b_s;
	word_t              sext;
	word_t              zext;
	word_t              res;
	logic               wr;
	reg_idx_t           dst;
	logic signed [63:0] sa;
	logic signed [63:0] sb;
	logic [63:0]        p;
	op   = ins[31:26];
	fn   = ins[5:0];
	a    = model_gpr[ins[25:21]];
	b    = model_gpr[ins[20:16]];
	b_s  = b;
	sext = {{16{ins[15]}}, ins[15:0]};
	zext = {16'h0000, ins[15:0]};
	res  = '0;
	wr   = 1'b1;
	dst  = ins[20:16]; // rt for I-type
	model_status = 2'b00;
	case (op)
		OP_RTYPE: begin
			dst = ins[15:11];
			case (fn)
				FN_SLL:  res = b << ins[10:6];
				FN_SRL:  res = b >> ins[10:6];
				FN_SRA:  res = b_s >>> ins[10:6];
				FN_SLLV: res = b << a[4:0];
				FN_SRLV: res = b >> a[4:0];
				FN_SRAV: res = b_s >>> a[4:0];
				FN_ADDU: res = a + b;
				FN_SUBU: res = a - b;
				FN_AND:  res = a & b;
				FN_OR:   res = a | b;
				FN_XOR:  res = a ^ b;
				FN_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
				FN_SLTU: res = (a < b) ? 32'd1 : 32'd0;
				FN_MULT, FN_MULTU: begin
					wr = 1'b0;
					sa = 64'($signed(a));
					sb = 64'($signed(b));
					p  = (fn == FN_MULT) ? sa * sb : {32'h0, a} * {32'h0, b};
					model_hi = p[63:32];
					model_lo = p[31:0];
				end
				FN_DIV, FN_DIVU: begin
					wr = 1'b0;
					sa = 64'($signed(a));
					sb = 64'($signed(b));
					if (b == '0) begin
						model_hi = a;
						model_lo = '1;
					end else if (fn == FN_DIV) begin
						p        = sa / sb; // Wide enough for min / -1
						model_lo = p[31:0];
						p        = sa % sb;
						model_hi = p[31:0];
					end else begin
						model_lo = a / b;
						model_hi = a % b;
					end
				end
				FN_MTHI: begin
					wr       = 1'b0;
					model_hi = a;
				end
				FN_MTLO: begin
					wr       = 1'b0;
					model_lo = a;
				end
				default: begin
					wr           = 1'b0;
					model_status = 2'b10;
				end
			endcase
		end
		OP_BEQ: begin
			wr           = 1'b0;
			model_status = (a == b) ? 2'b01 : 2'b00;
		end
		OP_BNE: begin
			wr           = 1'b0;
			model_status = (a != b) ? 2'b01 : 2'b00;
		end
		OP_ADDIU: res = a + sext;
		OP_SLTI:  res = ($signed(a) < $signed(sext)) ? 32'd1 : 32'd0;
		OP_SLTIU: res = (a < sext) ? 32'd1 : 32'd0;
		OP_ANDI:  res = a & zext;
		OP_ORI:   res = a | zext;
		OP_XORI:  res = a ^ zext;
		OP_LUI:   res = {ins[15:0], 16'h0000};
		default: begin
			wr           = 1'b0;
			model_status = 2'b10;
		end
	endcase
	if (wr) begin
		model_write_gpr(dst, res);
	end
endfunction

`endif

// File: tests/tb_exec_top.sv
`timescale 1ns/1ps

module tb_exec_top;
	import mips_pkg::*;

	`include "mips_model.svh"

	localparam int N_GPR    = 40;
	localparam int N_RTYPE  = 60;
	localparam int N_ITYPE  = 60;
	localparam int N_BRANCH = 20;
	localparam int N_MULDIV = 40;
	localparam int N_BAD    = 16;
	// Six bus transactions at most per instruction, plus the GPR sweeps
	localparam int NUM_TXN  = 35 + N_GPR + 1 + 32 + 64
		+ 6 * (N_RTYPE + N_ITYPE + N_BRANCH + N_MULDIV + N_BAD);
	localparam int ACK_LIMIT = 100;

	logic    clk;
	logic    rst_n;
	logic    wb_cyc;
	logic    wb_stb;
	logic    wb_we;
	wb_adr_t wb_adr;
	word_t   wb_dat_w;
	word_t   wb_dat_r;
	logic    wb_ack;
	integer  seed = 93;

	exec_top uut (
		.clk      (clk),
		.rst_n    (rst_n),
		.wb_cyc   (wb_cyc),
		.wb_stb   (wb_stb),
		.wb_we    (wb_we),
		.wb_adr   (wb_adr),
		.wb_dat_w (wb_dat_w),
		.wb_dat_r (wb_dat_r),
		.wb_ack   (wb_ack)
	);

	always #5 clk = ~clk;

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Regression failed");
		$fatal(1);
	endtask

	initial begin
		#(NUM_TXN * 40 * 10 * 2);
		abort_run("Timeout: test sequence did not finish in time");
	end

	task automatic check_value(input string name, input word_t actual, input word_t expected);
		if (actual !== expected) begin
			abort_run($sformatf("Error at %0d ns: %s is 0x%08h, expected 0x%08h",
				$time, name, actual, expected));
		end
	endtask

	function automatic int rand_below(input int n);
		rand_below = int'({$random(seed)} % n);
	endfunction

	function automatic word_t rand_word();
		rand_word = $random(seed);
	endfunction

	// Called 1 ns after a rising edge, returns at the same phase
	task automatic bus_cycle(input logic we, input wb_adr_t adr, input word_t wdata,
		output word_t rdata);
		int waited;
		wb_cyc   = 1'b1;
		wb_stb   = 1'b1;
		wb_we    = we;
		wb_adr   = adr;
		wb_dat_w = wdata;
		waited   = 0;
		do begin
			@(posedge clk);
			#1;
			waited++;
			if (waited > ACK_LIMIT) begin
				abort_run($sformatf("No ack from the slave for address 0x%02h", adr));
			end
		end while (!wb_ack);
		rdata = wb_dat_r;
		@(posedge clk); // Master sees ack at this edge
		#1;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we  = 1'b0;
		@(posedge clk);
		#1;
	endtask

	task automatic wb_write(input wb_adr_t adr, input word_t data);
		word_t unused_rd;
		bus_cycle(1'b1, adr, data, unused_rd);
	endtask

	task automatic wb_read(input wb_adr_t adr, output word_t data);
		bus_cycle(1'b0, adr, '0, data);
	endtask

	function automatic wb_adr_t gpr_addr(input reg_idx_t idx);
		gpr_addr = ADR_GPR_BASE | {1'b0, idx, 2'b00};
	endfunction

	task automatic load_gpr(input reg_idx_t idx, input word_t val);
		wb_write(gpr_addr(idx), val);
		model_write_gpr(idx, val);
	endtask

	task automatic check_gpr(input reg_idx_t idx);
		word_t got;
		wb_read(gpr_addr(idx), got);
		check_value($sformatf("gpr[%0d]", idx), got, model_gpr[idx]);
	endtask

	task automatic check_all_gprs();
		for (int i = 0; i < 32; i++) begin
			check_gpr(5'(i));
		end
	endtask

	task automatic check_status();
		word_t got;
		wb_read(ADR_STATUS, got);
		check_value("status", got, {30'h0, model_status});
	endtask

	task automatic check_hi_lo_status();
		word_t got;
		wb_read(ADR_HI, got);
		check_value("hi", got, model_hi);
		wb_read(ADR_LO, got);
		check_value("lo", got, model_lo);
		check_status();
	endtask

	task automatic issue_instr(input instr_t ins);
		wb_write(ADR_INSTR, ins);
		model_exec(ins);
	endtask

	function automatic instr_t encode_r(input reg_idx_t rs, input reg_idx_t rt,
		input reg_idx_t rd, input logic [4:0] sh, input logic [5:0] fn);
		encode_r = {OP_RTYPE, rs, rt, rd, sh, fn};
	endfunction

	function automatic instr_t encode_i(input logic [5:0] op, input reg_idx_t rs,
		input reg_idx_t rt, input logic [15:0] imm);
		encode_i = {op, rs, rt, imm};
	endfunction

	function automatic logic [5:0] pick_alu_funct(input int k);
		case (k)
			0:       pick_alu_funct = FN_SLL;
			1:       pick_alu_funct = FN_SRL;
			2:       pick_alu_funct = FN_SRA;
			3:       pick_alu_funct = FN_SLLV;
			4:       pick_alu_funct = FN_SRLV;
			5:       pick_alu_funct = FN_SRAV;
			6:       pick_alu_funct = FN_ADDU;
			7:       pick_alu_funct = FN_SUBU;
			8:       pick_alu_funct = FN_AND;
			9:       pick_alu_funct = FN_OR;
			10:      pick_alu_funct = FN_XOR;
			11:      pick_alu_funct = FN_SLT;
			default: pick_alu_funct = FN_SLTU;
		endcase
	endfunction

	function automatic logic [5:0] pick_imm_op(input int k);
		case (k)
			0:       pick_imm_op = OP_ADDIU;
			1:       pick_imm_op = OP_SLTI;
			2:       pick_imm_op = OP_SLTIU;
			3:       pick_imm_op = OP_ANDI;
			4:       pick_imm_op = OP_ORI;
			5:       pick_imm_op = OP_XORI;
			default: pick_imm_op = OP_LUI;
		endcase
	endfunction

	function automatic logic [5:0] pick_md_funct(input int k);
		case (k)
			0:       pick_md_funct = FN_MULT;
			1:       pick_md_funct = FN_MULTU;
			2:       pick_md_funct = FN_DIV;
			3:       pick_md_funct = FN_DIVU;
			4:       pick_md_funct = FN_MTHI;
			default: pick_md_funct = FN_MTLO;
		endcase
	endfunction

	// Opcodes outside the map, loads and stores first
	function automatic logic [5:0] pick_bad_opcode(input int k);
		case (k)
			0:       pick_bad_opcode = 6'h20; // LB
			1:       pick_bad_opcode = 6'h23; // LW
			2:       pick_bad_opcode = 6'h28; // SB
			3:       pick_bad_opcode = 6'h2B; // SW
			4:       pick_bad_opcode = 6'h24; // LBU
			5:       pick_bad_opcode = 6'h08; // ADDI
			6:       pick_bad_opcode = 6'h02; // J
			default: pick_bad_opcode = 6'h3F;
		endcase
	endfunction

	task automatic test_gpr_access();
		check_hi_lo_status(); // Reset values
		check_all_gprs();
		for (int i = 0; i < N_GPR; i++) begin
			load_gpr(5'(rand_below(32)), rand_word());
		end
		load_gpr(5'd0, 32'hFFFF_FFFF);
		check_all_gprs();
	endtask

	task automatic test_rtype();
		reg_idx_t rs;
		reg_idx_t rt;
		reg_idx_t rd;
		for (int i = 0; i < N_RTYPE; i++) begin
			rs = 5'(rand_below(32));
			rt = 5'(rand_below(32));
			rd = 5'(rand_below(32));
			load_gpr(rs, rand_word());
			load_gpr(rt, rand_word());
			issue_instr(encode_r(rs, rt, rd, 5'(rand_below(32)), pick_alu_funct(rand_below(13))));
			check_gpr(rd);
			check_status();
		end
	endtask

	task automatic test_itype();
		reg_idx_t    rs;
		reg_idx_t    rt;
		logic [15:0] imm;
		for (int i = 0; i < N_ITYPE; i++) begin
			rs = 5'(rand_below(32));
			rt = 5'(rand_below(32));
			case (rand_below(8))
				0:       imm = 16'h8000;
				1:       imm = 16'hFFFF;
				2:       imm = 16'h7FFF;
				3:       imm = 16'h0000;
				default: imm = 16'(rand_word());
			endcase
			load_gpr(rs, rand_word());
			issue_instr(encode_i(pick_imm_op(rand_below(7)), rs, rt, imm));
			check_gpr(rt);
			check_status();
		end
	endtask

	task automatic test_branches();
		reg_idx_t rs;
		reg_idx_t rt;
		word_t    a;
		for (int i = 0; i < N_BRANCH; i++) begin
			rs = 5'(1 + rand_below(31));
			rt = (rs == 5'd31) ? 5'd1 : rs + 5'd1;
			a  = rand_word();
			load_gpr(rs, a);
			load_gpr(rt, (i % 2 == 0) ? a : rand_word()); // Equal on even steps
			issue_instr(encode_i((i % 4 < 2) ? OP_BEQ : OP_BNE, rs, rt, 16'(rand_word())));
			check_status();
		end
		check_all_gprs();
	endtask

	task automatic test_muldiv();
		reg_idx_t   rs;
		reg_idx_t   rt;
		word_t      a;
		word_t      b;
		logic [5:0] fn;
		for (int i = 0; i < N_MULDIV; i++) begin
			rs = 5'(1 + rand_below(31));
			rt = (rs == 5'd31) ? 5'd1 : rs + 5'd1;
			a  = rand_word();
			b  = rand_word();
			fn = pick_md_funct(rand_below(6));
			case (i)
				0, 1: begin
					fn = (i == 0) ? FN_DIV : FN_DIVU;
					b  = '0;
				end
				2, 3: begin
					fn = (i == 2) ? FN_DIV : FN_DIVU;
					a  = 32'h8000_0000;
					b  = 32'hFFFF_FFFF;
				end
				4:       fn = FN_MTHI;
				5:       fn = FN_MTLO;
				default: ;
			endcase
			load_gpr(rs, a);
			load_gpr(rt, b);
			issue_instr(encode_r(rs, rt, 5'd0, 5'd0, fn));
			check_hi_lo_status();
		end
	endtask

	task automatic test_bad_opcodes();
		int     k;
		instr_t ins;
		for (int i = 0; i < N_BAD; i++) begin
			k = rand_below(9);
			if (k == 8) begin
				ins = encode_r(5'(rand_below(32)), 5'(rand_below(32)), 5'(rand_below(32)),
					5'(rand_below(32)), 6'h01); // Unused funct
			end else begin
				ins = {pick_bad_opcode(k), 26'(rand_word())};
			end
			issue_instr(ins);
			check_hi_lo_status();
		end
		check_all_gprs();
	endtask

	initial begin
		clk      = 1'b0;
		rst_n    = 1'b0;
		wb_cyc   = 1'b0;
		wb_stb   = 1'b0;
		wb_we    = 1'b0;
		wb_adr   = '0;
		wb_dat_w = '0;
		model_reset();
		repeat (2) @(posedge clk);
		#1;
		rst_n = 1'b1;
		test_gpr_access();
		test_rtype();
		test_itype();
		test_branches();
		test_muldiv();
		test_bad_opcodes();
		$display("Regression passed");
		$finish;
	end

endmodule

// File: logic/exec_top.sv
`timescale 1ns/1ps

module exec_top (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              wb_cyc,
	input  logic              wb_stb,
	input  logic              wb_we,
	input  mips_pkg::wb_adr_t wb_adr,
	input  mips_pkg::word_t   wb_dat_w,
	output mips_pkg::word_t   wb_dat_r,
	output logic              wb_ack
);
	import mips_pkg::*;

	instr_t     instr;
	reg_idx_t   host_raddr;
	logic       rf_we;
	reg_idx_t   rf_waddr;
	word_t      rf_wdata;
	logic       md_start;
	word_t      alu_result;
	logic       branch_taken;
	logic       illegal;
	logic       gpr_we;
	reg_idx_t   gpr_dest;
	muldiv_op_t md_op;
	logic       md_done;
	word_t      hi;
	word_t      lo;
	word_t      host_rdata;
	word_t      rs_val;
	word_t      rt_val;

	wb_exec_ctrl u_ctrl (
		.clk          (clk),
		.rst_n        (rst_n),
		.wb_cyc       (wb_cyc),
		.wb_stb       (wb_stb),
		.wb_we        (wb_we),
		.wb_adr       (wb_adr),
		.wb_dat_w     (wb_dat_w),
		.alu_result   (alu_result),
		.branch_taken (branch_taken),
		.illegal      (illegal),
		.gpr_we       (gpr_we),
		.gpr_dest     (gpr_dest),
		.md_op        (md_op),
		.md_done      (md_done),
		.hi           (hi),
		.lo           (lo),
		.host_rdata   (host_rdata),
		.wb_dat_r     (wb_dat_r),
		.wb_ack       (wb_ack),
		.instr        (instr),
		.host_raddr   (host_raddr),
		.rf_we        (rf_we),
		.rf_waddr     (rf_waddr),
		.rf_wdata     (rf_wdata),
		.md_start     (md_start)
	);

	reg_file u_rf (
		.clk     (clk),
		.rst_n   (rst_n),
		.raddr_a (instr[25:21]), // rs
		.raddr_b (instr[20:16]), // rt
		.raddr_c (host_raddr),
		.we      (rf_we),
		.waddr   (rf_waddr),
		.wdata   (rf_wdata),
		.rdata_a (rs_val),
		.rdata_b (rt_val),
		.rdata_c (host_rdata)
	);

	alu u_alu (
		.instr        (instr),
		.rs_val       (rs_val),
		.rt_val       (rt_val),
		.result       (alu_result),
		.branch_taken (branch_taken),
		.illegal      (illegal),
		.gpr_we       (gpr_we),
		.gpr_dest     (gpr_dest),
		.md_op        (md_op)
	);

	// Controller waits on done, so busy stays local to the unit
	muldiv_unit u_md (
		.clk    (clk),
		.rst_n  (rst_n),
		.start  (md_start),
		.op     (md_op),
		.rs_val (rs_val),
		.rt_val (rt_val),
		.busy   (),
		.done   (md_done),
		.hi     (hi),
		.lo     (lo)
	);

endmodule

// File: logic/wb_exec_ctrl.sv
`timescale 1ns/1ps

module wb_exec_ctrl (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 wb_cyc,
	input  logic                 wb_stb,
	input  logic                 wb_we,
	input  mips_pkg::wb_adr_t    wb_adr,
	input  mips_pkg::word_t      wb_dat_w,
	input  mips_pkg::word_t      alu_result,
	input  logic                 branch_taken,
	input  logic                 illegal,
	input  logic                 gpr_we,
	input  mips_pkg::reg_idx_t   gpr_dest,
	input  mips_pkg::muldiv_op_t md_op,
	input  logic                 md_done,
	input  mips_pkg::word_t      hi,
	input  mips_pkg::word_t      lo,
	input  mips_pkg::word_t      host_rdata,
	output mips_pkg::word_t      wb_dat_r,
	output logic                 wb_ack,
	output mips_pkg::instr_t     instr,
	output mips_pkg::reg_idx_t   host_raddr,
	output logic                 rf_we,
	output mips_pkg::reg_idx_t   rf_waddr,
	output mips_pkg::word_t      rf_wdata,
	output logic                 md_start
);
	import mips_pkg::*;

	typedef enum logic [1:0] {ST_IDLE, ST_EXEC, ST_WAIT_MD, ST_ACK} ctrl_state_t;

	ctrl_state_t state;
	logic        req;
	logic        is_gpr;
	logic        ack_q;
	logic [1:0]  status; // {illegal, branch taken}
	word_t       rd_data;

	assign req        = wb_cyc && wb_stb && (state == ST_IDLE);
	assign is_gpr     = wb_adr[7];
	assign host_raddr = wb_adr[6:2];
	assign md_start   = (state == ST_EXEC) && (md_op != MD_NONE);
	assign wb_ack     = ack_q || ((state == ST_WAIT_MD) && md_done); // Same cycle as done

	// Writeback owns the port during EXEC, host otherwise
	always_comb begin
		if (state == ST_EXEC) begin
			rf_we    = gpr_we;
			rf_waddr = gpr_dest;
			rf_wdata = alu_result;
		end else begin
			rf_we    = req && wb_we && is_gpr;
			rf_waddr = wb_adr[6:2];
			rf_wdata = wb_dat_w;
		end
	end

	always_comb begin
		if (is_gpr) begin
			rd_data = host_rdata;
		end else begin
			case (wb_adr)
				ADR_HI:     rd_data = hi;
				ADR_LO:     rd_data = lo;
				ADR_STATUS: rd_data = {30'b0, status};
				default:    rd_data = '0; // Includes the write-only INSTR
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state    <= ST_IDLE;
			ack_q    <= 1'b0;
			status   <= '0;
			wb_dat_r <= '0;
			instr    <= '0;
		end else begin
			ack_q <= 1'b0;
			case (state)
				ST_IDLE: begin
					if (req && wb_we && wb_adr == ADR_INSTR) begin
						instr    <= wb_dat_w;
						wb_dat_r <= '0;
						state    <= ST_EXEC;
					end else if (req) begin
						wb_dat_r <= wb_we ? '0 : rd_data;
						ack_q    <= 1'b1;
						state    <= ST_ACK;
					end
				end
				ST_EXEC: begin
					status <= {illegal, branch_taken};
					if (md_op != MD_NONE) begin
						state <= ST_WAIT_MD;
					end else begin
						ack_q <= 1'b1;
						state <= ST_ACK;
					end
				end
				ST_WAIT_MD: if (md_done) state <= ST_ACK;
				ST_ACK: if (!(wb_cyc && wb_stb)) state <= ST_IDLE; // Wait for stb release
				default: state <= ST_IDLE;
			endcase
		end
	end

	a_ack_in_cycle: assert property (@(posedge clk) disable iff (!rst_n)
		wb_ack |-> (wb_cyc && wb_stb));

endmodule

// File: logic/muldiv_unit.sv
`timescale 1ns/1ps

module muldiv_unit (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 start,
	input  mips_pkg::muldiv_op_t op,
	input  mips_pkg::word_t      rs_val,
	input  mips_pkg::word_t      rt_val,
	output logic                 busy,
	output logic                 done,
	output mips_pkg::word_t      hi,
	output mips_pkg::word_t      lo
);
	import mips_pkg::*;

	logic [63:0] prod_s;
	logic [63:0] prod_u;
	logic        is_signed;
	word_t       rs_mag;
	word_t       rt_mag;
	word_t       div_rem;
	word_t       div_quo;
	word_t       div_dvsr;
	logic [5:0]  div_cnt;
	logic        neg_q;
	logic        neg_r;
	logic [32:0] rem_shift;
	logic        fits;
	word_t       rem_next;
	word_t       quo_next;

	assign prod_s = 64'($signed(rs_val)) * 64'($signed(rt_val));
	assign prod_u = 64'(rs_val) * 64'(rt_val);

	assign is_signed = (op == MD_DIV);
	assign rs_mag    = (is_signed && rs_val[31]) ? -rs_val : rs_val;
	assign rt_mag    = (is_signed && rt_val[31]) ? -rt_val : rt_val;

	// One restoring step per cycle, dividend shifts out of quo
	assign rem_shift = {div_rem, div_quo[31]};
	assign fits      = (rem_shift >= {1'b0, div_dvsr});
	assign rem_next  = fits ? 32'(rem_shift - {1'b0, div_dvsr}) : rem_shift[31:0];
	assign quo_next  = {div_quo[30:0], fits};

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			busy    <= 1'b0;
			done    <= 1'b0;
			div_cnt <= '0;
			hi      <= '0;
			lo      <= '0;
		end else begin
			done <= 1'b0;
			if (start) begin
				case (op)
					MD_MULT: begin
						hi   <= prod_s[63:32];
						lo   <= prod_s[31:0];
						done <= 1'b1;
					end
					MD_MULTU: begin
						hi   <= prod_u[63:32];
						lo   <= prod_u[31:0];
						done <= 1'b1;
					end
					MD_MTHI: begin
						hi   <= rs_val;
						done <= 1'b1;
					end
					MD_MTLO: begin
						lo   <= rs_val;
						done <= 1'b1;
					end
					MD_DIV, MD_DIVU: begin
						if (rt_val == '0) begin
							hi   <= rs_val; // Divide by zero finishes at once
							lo   <= '1;
							done <= 1'b1;
						end else begin
							busy    <= 1'b1;
							div_cnt <= 6'd32;
						end
					end
					default: ;
				endcase
			end else if (busy) begin
				div_cnt <= div_cnt - 6'd1;
				if (div_cnt == 6'd1) begin
					busy <= 1'b0;
					done <= 1'b1;
					lo   <= neg_q ? -quo_next : quo_next; // Truncate toward zero
					hi   <= neg_r ? -rem_next : rem_next; // Sign of dividend
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (start) begin
			div_rem  <= '0;
			div_quo  <= rs_mag;
			div_dvsr <= rt_mag;
			neg_q    <= is_signed && (rs_val[31] ^ rt_val[31]);
			neg_r    <= is_signed && rs_val[31];
		end else if (busy) begin
			div_rem <= rem_next;
			div_quo <= quo_next;
		end
	end

	a_no_start_busy: assert property (@(posedge clk) disable iff (!rst_n)
		start |-> !busy);

endmodule

// File: logic/alu.sv
`timescale 1ns/1ps

module alu (
	input  mips_pkg::instr_t     instr,
	input  mips_pkg::word_t      rs_val,
	input  mips_pkg::word_t      rt_val,
	output mips_pkg::word_t      result,
	output logic                 branch_taken,
	output logic                 illegal,
	output logic                 gpr_we,
	output mips_pkg::reg_idx_t   gpr_dest,
	output mips_pkg::muldiv_op_t md_op
);
	import mips_pkg::*;

	logic [5:0] opcode;
	logic [5:0] funct;
	logic [4:0] shamt;
	reg_idx_t   rt_idx;
	reg_idx_t   rd_idx;
	logic [15:0] imm;
	word_t imm_s;
	word_t imm_z;

	assign opcode = instr[31:26];
	assign rt_idx = instr[20:16];
	assign rd_idx = instr[15:11];
	assign shamt  = instr[10:6];
	assign funct  = instr[5:0];
	assign imm    = instr[15:0];
	assign imm_s  = {{16{imm[15]}}, imm};
	assign imm_z  = {16'b0, imm};

	always_comb begin
		result       = '0;
		branch_taken = 1'b0;
		illegal      = 1'b0;
		gpr_we       = 1'b0;
		gpr_dest     = rt_idx; // I-type writes rt
		md_op        = MD_NONE;
		case (opcode)
			OP_RTYPE: begin
				gpr_dest = rd_idx;
				gpr_we   = 1'b1;
				case (funct)
					FN_SLL:  result = rt_val << shamt;
					FN_SRL:  result = rt_val >> shamt;
					FN_SRA:  result = $signed(rt_val) >>> shamt;
					FN_SLLV: result = rt_val << rs_val[4:0];
					FN_SRLV: result = rt_val >> rs_val[4:0];
					FN_SRAV: result = $signed(rt_val) >>> rs_val[4:0];
					FN_ADDU: result = rs_val + rt_val;
					FN_SUBU: result = rs_val - rt_val;
					FN_AND:  result = rs_val & rt_val;
					FN_OR:   result = rs_val | rt_val;
					FN_XOR:  result = rs_val ^ rt_val;
					FN_SLT:  result = {31'b0, $signed(rs_val) < $signed(rt_val)};
					FN_SLTU: result = {31'b0, rs_val < rt_val};
					FN_MULT,
					FN_MULTU,
					FN_DIV,
					FN_DIVU,
					FN_MTHI,
					FN_MTLO: begin
						gpr_we = 1'b0; // HI/LO only
						case (funct)
							FN_MULT:  md_op = MD_MULT;
							FN_MULTU: md_op = MD_MULTU;
							FN_DIV:   md_op = MD_DIV;
							FN_DIVU:  md_op = MD_DIVU;
							FN_MTHI:  md_op = MD_MTHI;
							default:  md_op = MD_MTLO;
						endcase
					end
					default: begin
						gpr_we  = 1'b0;
						illegal = 1'b1;
					end
				endcase
			end
			OP_BEQ:   branch_taken = (rs_val == rt_val);
			OP_BNE:   branch_taken = (rs_val != rt_val);
			OP_ADDIU: begin
				result = rs_val + imm_s;
				gpr_we = 1'b1;
			end
			OP_SLTI: begin
				result = {31'b0, $signed(rs_val) < $signed(imm_s)};
				gpr_we = 1'b1;
			end
			OP_SLTIU: begin
				result = {31'b0, rs_val < imm_s}; // Sign-extended, compared unsigned
				gpr_we = 1'b1;
			end
			OP_ANDI: begin
				result = rs_val & imm_z;
				gpr_we = 1'b1;
			end
			OP_ORI: begin
				result = rs_val | imm_z;
				gpr_we = 1'b1;
			end
			OP_XORI: begin
				result = rs_val ^ imm_z;
				gpr_we = 1'b1;
			end
			OP_LUI: begin
				result = {imm, 16'b0};
				gpr_we = 1'b1;
			end
			default: illegal = 1'b1; // Loads and stores land here
		endcase
	end

	// A decode never targets both the GPR file and HI/LO
	always_comb begin
		a_single_target: assert (!(gpr_we && md_op != MD_NONE));
	end

endmodule

// File: logic/reg_file.sv
`timescale 1ns/1ps

module reg_file (
	input  logic              clk,
	input  logic              rst_n,
	input  mips_pkg::reg_idx_t raddr_a,
	input  mips_pkg::reg_idx_t raddr_b,
	input  mips_pkg::reg_idx_t raddr_c,
	input  logic              we,
	input  mips_pkg::reg_idx_t waddr,
	input  mips_pkg::word_t    wdata,
	output mips_pkg::word_t    rdata_a,
	output mips_pkg::word_t    rdata_b,
	output mips_pkg::word_t    rdata_c
);
	import mips_pkg::*;

	word_t regs [32];

	assign rdata_a = regs[raddr_a];
	assign rdata_b = regs[raddr_b];
	assign rdata_c = regs[raddr_c]; // Host port

	// Index 0 is cleared by reset and never written
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (we && waddr != '0) begin
			regs[waddr] <= wdata;
		end
	end

	// All read ports see r0 straight from storage
	a_zero_reg: assert property (@(posedge clk) disable iff (!rst_n)
		regs[0] == '0);

endmodule

// File: logic/mips_pkg.sv
package mips_pkg;

	typedef logic [31:0] word_t;      // Data word, HI/LO and bus data
	typedef logic [31:0] instr_t;     // Raw MIPS instruction
	typedef logic [4:0]  reg_idx_t;   // GPR index
	typedef logic [7:0]  wb_adr_t;    // Byte address on the slave port
	typedef logic [2:0]  muldiv_op_t; // HI/LO operation select

	localparam muldiv_op_t MD_NONE  = 3'd0;
	localparam muldiv_op_t MD_MULT  = 3'd1;
	localparam muldiv_op_t MD_MULTU = 3'd2;
	localparam muldiv_op_t MD_DIV   = 3'd3;
	localparam muldiv_op_t MD_DIVU  = 3'd4;
	localparam muldiv_op_t MD_MTHI  = 3'd5;
	localparam muldiv_op_t MD_MTLO  = 3'd6;

	// Primary opcodes, instr[31:26]
	localparam logic [5:0] OP_RTYPE = 6'h00;
	localparam logic [5:0] OP_BEQ   = 6'h04;
	localparam logic [5:0] OP_BNE   = 6'h05;
	localparam logic [5:0] OP_ADDIU = 6'h09;
	localparam logic [5:0] OP_SLTI  = 6'h0A;
	localparam logic [5:0] OP_SLTIU = 6'h0B;
	localparam logic [5:0] OP_ANDI  = 6'h0C;
	localparam logic [5:0] OP_ORI   = 6'h0D;
	localparam logic [5:0] OP_XORI  = 6'h0E;
	localparam logic [5:0] OP_LUI   = 6'h0F;

	// R-type function codes, instr[5:0]
	localparam logic [5:0] FN_SLL   = 6'h00;
	localparam logic [5:0] FN_SRL   = 6'h02;
	localparam logic [5:0] FN_SRA   = 6'h03;
	localparam logic [5:0] FN_SLLV  = 6'h04;
	localparam logic [5:0] FN_SRLV  = 6'h06;
	localparam logic [5:0] FN_SRAV  = 6'h07;
	localparam logic [5:0] FN_MTHI  = 6'h11;
	localparam logic [5:0] FN_MTLO  = 6'h13;
	localparam logic [5:0] FN_MULT  = 6'h18;
	localparam logic [5:0] FN_MULTU = 6'h19;
	localparam logic [5:0] FN_DIV   = 6'h1A;
	localparam logic [5:0] FN_DIVU  = 6'h1B;
	localparam logic [5:0] FN_ADDU  = 6'h21;
	localparam logic [5:0] FN_SUBU  = 6'h23;
	localparam logic [5:0] FN_AND   = 6'h24;
	localparam logic [5:0] FN_OR    = 6'h25;
	localparam logic [5:0] FN_XOR   = 6'h26;
	localparam logic [5:0] FN_SLT   = 6'h2A;
	localparam logic [5:0] FN_SLTU  = 6'h2B;

	// Slave address map
	localparam wb_adr_t ADR_INSTR    = 8'h00; // Write only
	localparam wb_adr_t ADR_HI       = 8'h04;
	localparam wb_adr_t ADR_LO       = 8'h08;
	localparam wb_adr_t ADR_STATUS   = 8'h0C; // Bit 0 taken, bit 1 illegal
	localparam wb_adr_t ADR_GPR_BASE = 8'h80; // GPR index in bits 6:2

endpackage
